//--- tb.f
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_ctrl_fsm.sv
verilog/spi_bit_timer.sv
verilog/spi_shift_reg.sv
verilog/spi_pin_mux.sv
verilog/spi_board_top.sv
dv/spi_periph_model.sv
dv/spi_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module spi_tb -f tb.f -o spi_tb_sim

./obj_dir/spi_tb_sim > sim.log
cat sim.log

if grep -q "^All checks passed$" sim.log; then
   echo "Simulation PASSED"
else
   echo "Simulation FAILED"
   exit 1
fi

//--- dv/spi_tb.sv
`include "spi_macros.svh"

module spi_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_entries   = 12;
   localparam int max_cycles    = 2 + (2 * `SPI_WORD_BITS + 2) * `SPI_CLK_DIV;
   localparam int timeout_limit = num_entries * max_cycles + 200;

   logic                 clk_fpga = 1'b0;
   logic                 reset;
   logic                 go;
   spi_pkg::periph_sel_t periph_sel;
   spi_pkg::spi_count_t  num_bits;
   spi_pkg::spi_word_t   tx_data;
   spi_pkg::spi_word_t   rx_data;
   logic                 busy;
   logic                 done;
   logic [3:0]           pin_sclk;
   logic [3:0]           pin_sen;
   logic [3:0]           pin_mosi;
   logic [3:0]           pin_miso;
   spi_pkg::spi_state_t  fsm_state;

   spi_pkg::spi_word_t   resp_word [4];
   spi_pkg::spi_word_t   model_rx [4];
   int                   rise_cnt [4];
   int                   fall_cnt [4];
   int                   sel_cnt [4];

   // One row per transfer
   spi_pkg::periph_sel_t sel_tab [num_entries];
   spi_pkg::spi_count_t  nbits_tab [num_entries];
   spi_pkg::spi_word_t   tx_tab [num_entries];
   spi_pkg::spi_word_t   resp_tab [num_entries];
   logic                 stray_tab [num_entries];   // Extra go mid transfer
   spi_pkg::spi_word_t   exp_mosi_tab [num_entries];
   spi_pkg::spi_word_t   exp_rx_tab [num_entries];
   int                   exp_cyc_tab [num_entries];

   int                   errors = 0;
   int                   checks = 0;
   int                   cycle_count = 0;
   int                   seed = 32'ha55d;

   assign fsm_state = spi_board_top_i.spi_ctrl_fsm_i.state;

   spi_board_top spi_board_top_i (
      .clk_fpga(clk_fpga), .reset(reset), .go(go), .periph_sel(periph_sel),
      .num_bits(num_bits), .tx_data(tx_data), .rx_data(rx_data),
      .busy(busy), .done(done),
      .db_rx_sclk(pin_sclk[0]), .db_rx_sen(pin_sen[0]),
      .db_rx_mosi(pin_mosi[0]), .db_rx_miso(pin_miso[0]),
      .db_tx_sclk(pin_sclk[1]), .db_tx_sen(pin_sen[1]),
      .db_tx_mosi(pin_mosi[1]), .db_tx_miso(pin_miso[1]),
      .codec_sclk(pin_sclk[2]), .codec_sen(pin_sen[2]),
      .codec_mosi(pin_mosi[2]), .codec_miso(pin_miso[2]),
      .cgen_sclk(pin_sclk[3]), .cgen_sen(pin_sen[3]),
      .cgen_mosi(pin_mosi[3]), .cgen_miso(pin_miso[3]));

   for (genvar g = 0; g < 4; g++) begin : model_g
      spi_periph_model spi_periph_model_i (
         .sclk(pin_sclk[g]), .sen(pin_sen[g]), .mosi(pin_mosi[g]),
         .resp(resp_word[g]), .miso(pin_miso[g]), .rx_bits(model_rx[g]),
         .rise_count(rise_cnt[g]), .fall_count(fall_cnt[g]), .sel_count(sel_cnt[g]));
   end

   always #4 clk_fpga = ~clk_fpga;

   always @(posedge clk_fpga) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         $display("Simulation timed out after %0d cycles, a transfer never finished",
                  cycle_count);
         $display("Summary: %0d checks, %0d errors", checks, errors + 1);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
                  $time, what, got, expected);
      end
   endtask

   task automatic set_entry(input int idx, input spi_pkg::periph_sel_t sel,
                            input spi_pkg::spi_count_t nbits, input spi_pkg::spi_word_t tx,
                            input spi_pkg::spi_word_t resp, input logic stray);
      sel_tab[idx]   = sel;
      nbits_tab[idx] = nbits;
      tx_tab[idx]    = tx;
      resp_tab[idx]  = resp;
      stray_tab[idx] = stray;
   endtask

   task automatic build_table();
      spi_pkg::periph_sel_t sel;
      spi_pkg::spi_count_t  nbits;
      spi_pkg::spi_word_t   tx;
      spi_pkg::spi_word_t   resp;
      set_entry(0, 2'd0, 5'd8, 24'hA50000, 24'h5AFFFF, 1'b0);
      set_entry(1, 2'd1, 5'd24, 24'h123456, 24'hFEDCBA, 1'b0);
      set_entry(2, 2'd2, 5'd16, 24'hC0DE00, 24'h80017F, 1'b0);
      set_entry(3, 2'd3, 5'd1, 24'h800000, 24'h800000, 1'b0);
      set_entry(4, 2'd2, 5'd12, 24'hABC000, 24'h5A5000, 1'b1);
      set_entry(5, 2'd0, 5'd24, 24'hFFFFFF, 24'h000001, 1'b0);
      for (int i = 6; i < num_entries; i++) begin
         sel   = spi_pkg::periph_sel_t'($random(seed));
         nbits = spi_pkg::spi_count_t'(1 + ($unsigned($random(seed)) % `SPI_WORD_BITS));
         tx    = spi_pkg::spi_word_t'($random(seed));
         resp  = spi_pkg::spi_word_t'($random(seed));
         set_entry(i, sel, nbits, tx, resp, i == 9);
      end
      // Top num_bits of each word moved to the low end
      for (int i = 0; i < num_entries; i++) begin
         exp_mosi_tab[i] = tx_tab[i] >> (`SPI_WORD_BITS - int'(nbits_tab[i]));
         exp_rx_tab[i]   = resp_tab[i] >> (`SPI_WORD_BITS - int'(nbits_tab[i]));
         exp_cyc_tab[i]  = 2 + (2 * int'(nbits_tab[i]) + 2) * `SPI_CLK_DIV;
      end
   endtask

   task automatic check_reset_state();
      check_equal("busy after reset", 32'(busy), 32'd0);
      check_equal("done after reset", 32'(done), 32'd0);
      check_equal("sen pins after reset", 32'(pin_sen), 32'hF);
      check_equal("sclk pins after reset", 32'(pin_sclk), 32'h0);
      check_equal("mosi pins after reset", 32'(pin_mosi), 32'h0);
      check_equal("rx_data after reset", 32'(rx_data), 32'h0);
      check_equal("controller state after reset", 32'(fsm_state), 32'(spi_pkg::st_idle));
   endtask

   task automatic run_entry(input int idx);
      int                   rise0 [4];
      int                   fall0 [4];
      int                   sel0 [4];
      int                   cycles;
      logic                 got_done;
      spi_pkg::periph_sel_t sel;
      spi_pkg::spi_word_t   mask;
      logic [3:0]           idle_pins;
      sel       = sel_tab[idx];
      mask      = spi_pkg::spi_word_t'((32'd1 << nbits_tab[idx]) - 32'd1);
      idle_pins = ~(4'b0001 << sel);   // Pin groups that must stay quiet
      @(posedge clk_fpga);
      rise0 = rise_cnt;
      fall0 = fall_cnt;
      sel0  = sel_cnt;
      for (int m = 0; m < 4; m++) begin
         resp_word[m] <= (m == int'(sel)) ? resp_tab[idx] : ~resp_tab[idx];
      end
      periph_sel <= sel;
      num_bits   <= nbits_tab[idx];
      tx_data    <= tx_tab[idx];
      go         <= 1'b1;
      cycles   = 0;
      got_done = 1'b0;
      while (!got_done) begin
         @(posedge clk_fpga);
         if (stray_tab[idx] && cycles == exp_cyc_tab[idx] / 2) begin
            go         <= 1'b1;   // Must be dropped while busy
            periph_sel <= sel + 2'd1;
         end else begin
            go <= 1'b0;
         end
         @(negedge clk_fpga);
         cycles++;
         if (done) begin
            got_done = 1'b1;
         end else begin
            check_equal($sformatf("entry %0d busy", idx), 32'(busy), 32'd1);
            check_equal($sformatf("entry %0d idle mosi pins", idx),
                        32'(pin_mosi & idle_pins), 32'd0);
         end
      end
      check_equal($sformatf("entry %0d cycles", idx), 32'(cycles), 32'(exp_cyc_tab[idx]));
      check_equal($sformatf("entry %0d rx_data", idx), 32'(rx_data), 32'(exp_rx_tab[idx]));
      for (int m = 0; m < 4; m++) begin
         if (m == int'(sel)) begin
            check_equal($sformatf("entry %0d model %0d rising edges", idx, m),
                        32'(rise_cnt[m] - rise0[m]), 32'(nbits_tab[idx]));
            check_equal($sformatf("entry %0d model %0d selects", idx, m),
                        32'(sel_cnt[m] - sel0[m]), 32'd1);
            check_equal($sformatf("entry %0d model %0d mosi bits", idx, m),
                        32'(model_rx[m] & mask), 32'(exp_mosi_tab[idx]));
         end else begin
            check_equal($sformatf("entry %0d idle model %0d edges", idx, m),
                        32'(rise_cnt[m] - rise0[m] + fall_cnt[m] - fall0[m]), 32'd0);
            check_equal($sformatf("entry %0d idle model %0d selects", idx, m),
                        32'(sel_cnt[m] - sel0[m]), 32'd0);
         end
      end
      @(negedge clk_fpga);
      check_equal($sformatf("entry %0d done width", idx), 32'(done), 32'd0);
      check_equal($sformatf("entry %0d busy after done", idx), 32'(busy), 32'd0);
   endtask

   initial begin
      reset      = 1'b1;
      go         = 1'b0;
      periph_sel = '0;
      num_bits   = '0;
      tx_data    = '0;
      for (int m = 0; m < 4; m++) begin
         resp_word[m] = '0;
      end
      build_table();
      repeat (3) @(posedge clk_fpga);
      reset <= 1'b0;
      @(negedge clk_fpga);
      check_reset_state();
      for (int i = 0; i < num_entries; i++) begin
         run_entry(i);
      end
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- dv/spi_periph_model.sv
`include "spi_macros.svh"

module spi_periph_model (
   input  logic               sclk,
   input  logic               sen,
   input  logic               mosi,
   input  spi_pkg::spi_word_t resp,
   output logic               miso,
   output spi_pkg::spi_word_t rx_bits,
   output int                 rise_count,
   output int                 fall_count,
   output int                 sel_count
);

   timeunit 1ns;
   timeprecision 1ps;

   int                 fall_base;
   int                 out_idx;
   spi_pkg::spi_word_t out_word;

   initial begin
      rx_bits    = '0;
      rise_count = 0;
      fall_count = 0;
      sel_count  = 0;
      fall_base  = 0;
   end

   // Bits already sent in this selection
   assign out_idx  = fall_count - fall_base;
   assign out_word = resp << out_idx;
   assign miso     = out_word[`SPI_WORD_BITS-1];   // MSB first, zero once exhausted

   always @(negedge sen) begin
      sel_count <= sel_count + 1;
      fall_base <= fall_count;
   end

   always @(posedge sclk) begin
      rise_count <= rise_count + 1;
      if (!sen) begin
         rx_bits <= {rx_bits[`SPI_WORD_BITS-2:0], mosi};
      end
   end

   always @(negedge sclk) begin
      fall_count <= fall_count + 1;   // Next response bit goes out here
   end

endmodule

//--- verilog/spi_board_top.sv
module spi_board_top (
   input  logic                 clk_fpga,
   input  logic                 reset,
   input  logic                 go,
   input  spi_pkg::periph_sel_t periph_sel,
   input  spi_pkg::spi_count_t  num_bits,
   input  spi_pkg::spi_word_t   tx_data,
   output spi_pkg::spi_word_t   rx_data,
   output logic                 busy,
   output logic                 done,
   output logic                 db_rx_sclk,
   output logic                 db_rx_sen,
   output logic                 db_rx_mosi,
   input  logic                 db_rx_miso,
   output logic                 db_tx_sclk,
   output logic                 db_tx_sen,
   output logic                 db_tx_mosi,
   input  logic                 db_tx_miso,
   output logic                 codec_sclk,
   output logic                 codec_sen,
   output logic                 codec_mosi,
   input  logic                 codec_miso,
   output logic                 cgen_sclk,
   output logic                 cgen_sen,
   output logic                 cgen_mosi,
   input  logic                 cgen_miso
);

   logic                timer_start;
   logic                shift_load;
   logic                sclk_run;
   logic                half_tick;
   logic                rise_tick;
   logic                fall_tick;
   logic                last_bit;
   logic                sclk;
   logic                mosi;
   logic                miso;
   spi_pkg::periph_en_t periph_en;

   spi_ctrl_fsm spi_ctrl_fsm_i (
      .clk_fpga(clk_fpga), .reset(reset), .go(go), .periph_sel(periph_sel),
      .last_bit(last_bit), .half_tick(half_tick), .timer_start(timer_start),
      .shift_load(shift_load), .sclk_run(sclk_run), .periph_en(periph_en),
      .busy(busy), .done(done));

   spi_bit_timer spi_bit_timer_i (
      .clk_fpga(clk_fpga), .reset(reset), .timer_start(timer_start),
      .num_bits(num_bits), .sclk_run(sclk_run), .half_tick(half_tick),
      .rise_tick(rise_tick), .fall_tick(fall_tick), .last_bit(last_bit),
      .sclk(sclk));

   spi_shift_reg spi_shift_reg_i (
      .clk_fpga(clk_fpga), .reset(reset), .shift_load(shift_load),
      .tx_data(tx_data), .num_bits(num_bits), .rise_tick(rise_tick),
      .fall_tick(fall_tick), .miso(miso), .mosi(mosi), .rx_data(rx_data));

   spi_pin_mux spi_pin_mux_i (
      .sclk(sclk), .mosi(mosi), .periph_en(periph_en), .miso(miso),
      .db_rx_sclk(db_rx_sclk), .db_rx_sen(db_rx_sen),
      .db_rx_mosi(db_rx_mosi), .db_rx_miso(db_rx_miso),
      .db_tx_sclk(db_tx_sclk), .db_tx_sen(db_tx_sen),
      .db_tx_mosi(db_tx_mosi), .db_tx_miso(db_tx_miso),
      .codec_sclk(codec_sclk), .codec_sen(codec_sen),
      .codec_mosi(codec_mosi), .codec_miso(codec_miso),
      .cgen_sclk(cgen_sclk), .cgen_sen(cgen_sen),
      .cgen_mosi(cgen_mosi), .cgen_miso(cgen_miso));

endmodule

//--- verilog/spi_pin_mux.sv
module spi_pin_mux (
   input  logic                sclk,
   input  logic                mosi,
   input  spi_pkg::periph_en_t periph_en,
   output logic                miso,
   output logic                db_rx_sclk,
   output logic                db_rx_sen,
   output logic                db_rx_mosi,
   input  logic                db_rx_miso,
   output logic                db_tx_sclk,
   output logic                db_tx_sen,
   output logic                db_tx_mosi,
   input  logic                db_tx_miso,
   output logic                codec_sclk,
   output logic                codec_sen,
   output logic                codec_mosi,
   input  logic                codec_miso,
   output logic                cgen_sclk,
   output logic                cgen_sen,
   output logic                cgen_mosi,
   input  logic                cgen_miso
);

   assign {db_rx_sen, db_tx_sen, codec_sen, cgen_sen} =
      {periph_en[0], periph_en[1], periph_en[2], periph_en[3]};

   // Idle pins held low
   assign {db_rx_sclk, db_rx_mosi} = ~periph_en[0] ? {sclk, mosi} : 2'b00;
   assign {db_tx_sclk, db_tx_mosi} = ~periph_en[1] ? {sclk, mosi} : 2'b00;
   assign {codec_sclk, codec_mosi} = ~periph_en[2] ? {sclk, mosi} : 2'b00;
   assign {cgen_sclk, cgen_mosi}   = ~periph_en[3] ? {sclk, mosi} : 2'b00;

   assign miso = (~periph_en[0] & db_rx_miso) |
                 (~periph_en[1] & db_tx_miso) |
                 (~periph_en[2] & codec_miso) |
                 (~periph_en[3] & cgen_miso);   // Deselected parts masked off

endmodule

//--- verilog/spi_shift_reg.sv
`include "spi_macros.svh"

module spi_shift_reg (
   input  logic                clk_fpga,
   input  logic                reset,
   input  logic                shift_load,
   input  spi_pkg::spi_word_t  tx_data,
   input  spi_pkg::spi_count_t num_bits,
   input  logic                rise_tick,
   input  logic                fall_tick,
   input  logic                miso,
   output logic                mosi,
   output spi_pkg::spi_word_t  rx_data
);

   spi_pkg::spi_word_t  tx_reg;
   spi_pkg::spi_count_t rx_left;   // Samples still expected

   assign mosi = tx_reg[`SPI_WORD_BITS-1];   // MSB first

   always_ff @(posedge clk_fpga) begin
      if (shift_load) begin
         tx_reg <= tx_data;
      end else if (fall_tick) begin
         tx_reg <= {tx_reg[`SPI_WORD_BITS-2:0], 1'b0};
      end
   end

   // Capture side, fills from the low end so the result lands right-aligned
   always_ff @(posedge clk_fpga) begin
      if (reset) begin
         rx_data <= '0;
         rx_left <= '0;
      end else if (shift_load) begin
         rx_data <= '0;
         rx_left <= num_bits;
      end else if (rise_tick && (rx_left != '0)) begin
         rx_data <= {rx_data[`SPI_WORD_BITS-2:0], miso};
         rx_left <= rx_left - 1'b1;
      end
   end

endmodule

//--- verilog/spi_bit_timer.sv
`include "spi_macros.svh"

module spi_bit_timer (
   input  logic                clk_fpga,
   input  logic                reset,
   input  logic                timer_start,
   input  spi_pkg::spi_count_t num_bits,
   input  logic                sclk_run,
   output logic                half_tick,
   output logic                rise_tick,
   output logic                fall_tick,
   output logic                last_bit,
   output logic                sclk
);

   localparam int DIV_W = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);

   logic                running;
   logic [DIV_W-1:0]    div_cnt;
   spi_pkg::spi_count_t bits_left;

   assign half_tick = running && (div_cnt == DIV_LAST);
   assign rise_tick = half_tick && sclk_run && !sclk;
   assign fall_tick = half_tick && sclk_run && sclk;
   assign last_bit  = (bits_left == spi_pkg::spi_count_t'(1));

   always_ff @(posedge clk_fpga) begin
      if (reset) begin
         running   <= 1'b0;
         div_cnt   <= '0;
         sclk      <= 1'b0;
         bits_left <= '0;
      end else if (timer_start) begin
         running   <= 1'b1;
         div_cnt   <= '0;
         sclk      <= 1'b0;
         bits_left <= num_bits;
      end else begin
         if (running) begin
            div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
         end
         if (half_tick && sclk_run) begin
            sclk <= ~sclk;
         end
         if (fall_tick) begin
            bits_left <= bits_left - 1'b1;   // One bit done per falling edge
         end
         if (half_tick && !sclk_run && (bits_left == '0)) begin
            running <= 1'b0;   // End of trail half period
         end
      end
   end

endmodule

//--- verilog/spi_ctrl_fsm.sv
module spi_ctrl_fsm (
   input  logic                 clk_fpga,
   input  logic                 reset,
   input  logic                 go,
   input  spi_pkg::periph_sel_t periph_sel,
   input  logic                 last_bit,
   input  logic                 half_tick,
   output logic                 timer_start,
   output logic                 shift_load,
   output logic                 sclk_run,
   output spi_pkg::periph_en_t  periph_en,
   output logic                 busy,
   output logic                 done
);

   spi_pkg::spi_state_t state;
   logic                fall_half;   // Next shift tick is a falling edge
   logic                accept;

   assign accept     = go && (state == spi_pkg::st_idle);   // Dropped while busy
   assign shift_load = accept;
   assign sclk_run   = (state == spi_pkg::st_shift);
   assign busy       = (state != spi_pkg::st_idle);

   always_ff @(posedge clk_fpga) begin
      if (reset) begin
         state       <= spi_pkg::st_idle;
         periph_en   <= '1;
         timer_start <= 1'b0;
         fall_half   <= 1'b0;
         done        <= 1'b0;
      end else begin
         timer_start <= accept;
         done        <= 1'b0;
         case (state)
            spi_pkg::st_idle: begin
               if (go) begin
                  state     <= spi_pkg::st_lead;
                  periph_en <= ~(spi_pkg::periph_en_t'(1) << periph_sel);
               end
            end
            spi_pkg::st_lead: begin
               fall_half <= 1'b0;
               if (half_tick) begin
                  state <= spi_pkg::st_shift;
               end
            end
            spi_pkg::st_shift: begin
               if (half_tick) begin
                  fall_half <= ~fall_half;
                  if (fall_half && last_bit) begin   // Falling half of final bit
                     state <= spi_pkg::st_trail;
                  end
               end
            end
            spi_pkg::st_trail: begin
               if (half_tick) begin
                  state     <= spi_pkg::st_idle;
                  periph_en <= '1;
                  done      <= 1'b1;
               end
            end
            default: begin
               state     <= spi_pkg::st_idle;
               periph_en <= '1;
            end
         endcase
      end
   end

endmodule

//--- verilog/spi_pkg.sv
`include "spi_macros.svh"

package spi_pkg;

   typedef logic [`SPI_WORD_BITS-1:0]  spi_word_t;
   typedef logic [`SPI_COUNT_BITS-1:0] spi_count_t;

   // 0 db rx, 1 db tx, 2 codec, 3 clock gen
   typedef logic [1:0]                 periph_sel_t;

   // Active low, same index order as periph_sel_t
   typedef logic [`SPI_NUM_PERIPH-1:0] periph_en_t;

   typedef enum logic [1:0] {
      st_idle,
      st_lead,
      st_shift,
      st_trail
   } spi_state_t;

endpackage

//--- verilog/spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Longest transfer, also the width of the data ports
`define SPI_WORD_BITS 24

// System clocks per serial clock half period
`define SPI_CLK_DIV 4

// Peripherals sharing the serial engine
`define SPI_NUM_PERIPH 4

// Wide enough to hold SPI_WORD_BITS
`define SPI_COUNT_BITS 5

`endif
